// File: hdl/toom_pkg.sv
`default_nettype none

package toom_pkg;

    // Operand geometry
    localparam int LIMB_W_DEFAULT = 280;
    localparam int NUM_POINTS = 7;

    // Growth from scaling a limb by up to x^3
    localparam int EVAL_EXT = 3;

    typedef logic [LIMB_W_DEFAULT-1:0] limb_t;
    typedef logic [LIMB_W_DEFAULT+EVAL_EXT-1:0] opnd_t;
    typedef logic [2*(LIMB_W_DEFAULT+EVAL_EXT)-1:0] pprod_t;
    typedef logic [8*LIMB_W_DEFAULT-1:0] result_t;

    typedef enum logic [2:0] {
        PH_EVAL,
        PH_MUL_PAIR,
        PH_MUL_WAIT,
        PH_INTERP,
        PH_COMBINE,
        PH_DONE
    } phase_t;

    // One solve pass runs SOLVE through B2_WAIT, the second pass is set up by PASS2
    typedef enum logic [2:0] {
        IS_IDLE,
        IS_SOLVE,
        IS_A1_WAIT,
        IS_A2_WAIT,
        IS_B1_WAIT,
        IS_B2_WAIT,
        IS_PASS2
    } interp_step_t;

endpackage

`default_nettype wire

// File: hdl/clmul_serial.sv
`default_nettype none

module clmul_serial #(
    parameter int LIMB_W = toom_pkg::LIMB_W_DEFAULT
) (
    input  wire logic                                      clk,
    input  wire logic                                      start,
    input  wire logic [LIMB_W+toom_pkg::EVAL_EXT-1:0]      x,
    input  wire logic [LIMB_W+toom_pkg::EVAL_EXT-1:0]      y,
    output logic      [2*(LIMB_W+toom_pkg::EVAL_EXT)-1:0]  p,
    output logic                                           done
);

    localparam int OW = LIMB_W + toom_pkg::EVAL_EXT;
    localparam int PW = 2 * OW;
    localparam int CW = $clog2(OW + 1);

    logic [OW-1:0] xr;
    logic [OW-1:0] yr;
    logic [PW-1:0] acc;
    logic [CW-1:0] cnt;

    // Horner scan of y from the top bit, one partial step per cycle
    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (start) begin
            xr  <= x;
            yr  <= y;
            acc <= '0;
            cnt <= CW'(OW);
        end else if (cnt != '0) begin
            acc  <= {acc[PW-2:0], 1'b0} ^ (yr[OW-1] ? PW'(xr) : '0);
            yr   <= yr << 1;
            cnt  <= cnt - 1'b1;
            done <= (cnt == CW'(1));
        end
    end

    assign p = acc;

endmodule

`default_nettype wire

// File: hdl/gf2_exact_div.sv
`default_nettype none

module gf2_exact_div #(
    parameter int LIMB_W  = toom_pkg::LIMB_W_DEFAULT,
    parameter int DIVISOR = 3
) (
    input  wire logic                                      clk,
    input  wire logic                                      start,
    input  wire logic [2*(LIMB_W+toom_pkg::EVAL_EXT)-1:0]  dividend,
    output logic      [2*(LIMB_W+toom_pkg::EVAL_EXT)-1:0]  quotient,
    output logic                                           done
);

    localparam int PW  = 2 * (LIMB_W + toom_pkg::EVAL_EXT);
    localparam int DEG = $clog2(DIVISOR + 1) - 1;
    localparam int CW  = $clog2(PW);
    localparam logic [DEG:0] POLY = (DEG + 1)'(DIVISOR);

    logic [DEG-1:0] rem;
    logic [PW-1:0]  sh;
    logic [PW-1:0]  q;
    logic [CW-1:0]  cnt;
    logic [DEG:0]   t;

    // Remainder with the next dividend bit appended
    assign t = {rem, sh[PW-1]};

    // Top dividend bit goes straight into the remainder, it never yields a quotient bit
    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (start) begin
            rem <= DEG'(dividend[PW-1]);
            sh  <= dividend << 1;
            q   <= '0;
            cnt <= CW'(PW - 1);
        end else if (cnt != '0) begin
            rem  <= t[DEG-1:0] ^ (t[DEG] ? POLY[DEG-1:0] : '0);
            q    <= {q[PW-2:0], t[DEG]};
            sh   <= sh << 1;
            cnt  <= cnt - 1'b1;
            done <= (cnt == CW'(1));
        end
    end

    assign quotient = q;

endmodule

`default_nettype wire

// File: hdl/toom4_eval.sv
`default_nettype none

module toom4_eval #(
    parameter int LIMB_W = toom_pkg::LIMB_W_DEFAULT
) (
    input  wire logic                                  clk,
    input  wire logic                                  start,
    input  wire logic [LIMB_W-1:0]                     a0,
    input  wire logic [LIMB_W-1:0]                     a1,
    input  wire logic [LIMB_W-1:0]                     a2,
    input  wire logic [LIMB_W-1:0]                     a3,
    input  wire logic [LIMB_W-1:0]                     b0,
    input  wire logic [LIMB_W-1:0]                     b1,
    input  wire logic [LIMB_W-1:0]                     b2,
    input  wire logic [LIMB_W-1:0]                     b3,
    output logic      [LIMB_W+toom_pkg::EVAL_EXT-1:0]  ua0, ua1, ua2, ua3, ua4, ua5, ua6,
    output logic      [LIMB_W+toom_pkg::EVAL_EXT-1:0]  ub0, ub1, ub2, ub3, ub4, ub5, ub6,
    output logic                                       done
);

    localparam int OW = LIMB_W + toom_pkg::EVAL_EXT;

    // Points 0, 1, x, x+1, 1/x, 1/(x+1), inf; reciprocal points in homogeneous form
    function automatic logic [OW-1:0] eval_pt(input int k, input logic [LIMB_W-1:0] l0,
            input logic [LIMB_W-1:0] l1, input logic [LIMB_W-1:0] l2,
            input logic [LIMB_W-1:0] l3);
        logic [OW-1:0] s0;
        logic [OW-1:0] s1;
        logic [OW-1:0] s2;
        logic [OW-1:0] s3;
        s0 = OW'(l0);
        s1 = OW'(l1);
        s2 = OW'(l2);
        s3 = OW'(l3);
        case (k)
            0: return s0;
            1: return s0 ^ s1 ^ s2 ^ s3;
            2: return s0 ^ (s1 << 1) ^ (s2 << 2) ^ (s3 << 3);
            3: return s0 ^ s1 ^ (s1 << 1) ^ s2 ^ (s2 << 2)
                   ^ s3 ^ (s3 << 1) ^ (s3 << 2) ^ (s3 << 3);
            4: return (s0 << 3) ^ (s1 << 2) ^ (s2 << 1) ^ s3;
            5: return s0 ^ (s0 << 1) ^ (s0 << 2) ^ (s0 << 3)
                   ^ s1 ^ (s1 << 2) ^ s2 ^ (s2 << 1) ^ s3;
            default: return s3;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        done <= start;
        if (start) begin
            ua0 <= eval_pt(0, a0, a1, a2, a3);
            ua1 <= eval_pt(1, a0, a1, a2, a3);
            ua2 <= eval_pt(2, a0, a1, a2, a3);
            ua3 <= eval_pt(3, a0, a1, a2, a3);
            ua4 <= eval_pt(4, a0, a1, a2, a3);
            ua5 <= eval_pt(5, a0, a1, a2, a3);
            ua6 <= eval_pt(6, a0, a1, a2, a3);
            ub0 <= eval_pt(0, b0, b1, b2, b3);
            ub1 <= eval_pt(1, b0, b1, b2, b3);
            ub2 <= eval_pt(2, b0, b1, b2, b3);
            ub3 <= eval_pt(3, b0, b1, b2, b3);
            ub4 <= eval_pt(4, b0, b1, b2, b3);
            ub5 <= eval_pt(5, b0, b1, b2, b3);
            ub6 <= eval_pt(6, b0, b1, b2, b3);
        end
    end

endmodule

`default_nettype wire

// File: hdl/toom4_interp.sv
`default_nettype none

module toom4_interp #(
    parameter int LIMB_W = toom_pkg::LIMB_W_DEFAULT
) (
    input  wire logic                                      clk,
    input  wire logic                                      start,
    input  wire logic [2*(LIMB_W+toom_pkg::EVAL_EXT)-1:0]  r0, r1, r2, r3, r4, r5, r6,
    output logic      [2*(LIMB_W+toom_pkg::EVAL_EXT)-1:0]  c0, c1, c2, c3, c4, c5, c6,
    output logic                                           done
);

    localparam int PW = 2 * (LIMB_W + toom_pkg::EVAL_EXT);

    // Constant multipliers, bit i set means x^i
    localparam logic [7:0] X3 = 8'h08;
    localparam logic [7:0] X4 = 8'h10;
    localparam logic [7:0] X5 = 8'h20;
    localparam logic [7:0] X6 = 8'h40;
    localparam logic [7:0] Y3 = 8'h0f;
    localparam logic [7:0] Y4 = 8'h11;
    localparam logic [7:0] Y5 = 8'h33;
    localparam logic [7:0] Y6 = 8'h55;

    function automatic logic [PW-1:0] cmul(input logic [PW-1:0] z, input logic [7:0] poly);
        logic [PW-1:0] acc;
        acc = '0;
        for (int i = 0; i < 8; i++) begin
            if (poly[i]) begin
                acc ^= z << i;
            end
        end
        return acc;
    endfunction

    toom_pkg::interp_step_t step;

    logic [PW-1:0] wk [toom_pkg::NUM_POINTS];
    logic [PW-1:0] g;
    logic [PW-1:0] h;
    logic [PW-1:0] alpha;
    logic          pass;

    // Point values with c0 and c6 removed, still scaled by x or x+1
    logic [PW-1:0] pt, qt, rt, st, et;

    logic          dy_start, dt_start;
    logic [PW-1:0] dy_in, dt_in;
    logic [PW-1:0] dy_q, dt_q;
    logic          dy_done, dt_done;

    assign pt = r2 ^ r0 ^ cmul(r6, X6);
    assign qt = r4 ^ cmul(r0, X6) ^ r6;
    assign rt = r3 ^ r0 ^ cmul(r6, Y6);
    assign st = r5 ^ cmul(r0, Y6) ^ r6;
    assign et = r1 ^ r0 ^ r6;

    // Divide by x+1
    gf2_exact_div #(.LIMB_W(LIMB_W), .DIVISOR(3)) u_div_y (
        .clk(clk), .start(dy_start), .dividend(dy_in), .quotient(dy_q), .done(dy_done)
    );

    // Divide by x^2+x+1
    gf2_exact_div #(.LIMB_W(LIMB_W), .DIVISOR(7)) u_div_t (
        .clk(clk), .start(dt_start), .dividend(dt_in), .quotient(dt_q), .done(dt_done)
    );

    // Each pass solves M = (x+1)^4 a + x(x+1)^2 b, N = x^4 a + x^2(x+1) b
    // from g = xM and h = (x+1)N
    always_ff @(posedge clk) begin
        done     <= 1'b0;
        dy_start <= 1'b0;
        dt_start <= 1'b0;
        if (start) begin
            wk[0] <= r0;
            wk[1] <= pt;
            wk[2] <= rt;
            wk[3] <= et;
            wk[6] <= r6;
            g     <= pt ^ qt;
            h     <= rt ^ st;
            pass  <= 1'b0;
            step  <= toom_pkg::IS_SOLVE;
        end else begin
            case (step)
                toom_pkg::IS_IDLE: ;
                toom_pkg::IS_SOLVE: begin
                    dy_start <= 1'b1;
                    dy_in    <= (g ^ h) >> 1;
                    step     <= toom_pkg::IS_A1_WAIT;
                end
                toom_pkg::IS_A1_WAIT: begin
                    if (dy_done && !dy_start) begin
                        dt_start <= 1'b1;
                        dt_in    <= dy_q;
                        step     <= toom_pkg::IS_A2_WAIT;
                    end
                end
                toom_pkg::IS_A2_WAIT: begin
                    if (dt_done && !dt_start) begin
                        alpha    <= dt_q;
                        dy_start <= 1'b1;
                        dy_in    <= ((g >> 1) ^ cmul(dt_q, Y4)) >> 1;
                        step     <= toom_pkg::IS_B1_WAIT;
                    end
                end
                toom_pkg::IS_B1_WAIT: begin
                    if (dy_done && !dy_start) begin
                        dy_start <= 1'b1;
                        dy_in    <= dy_q;
                        step     <= toom_pkg::IS_B2_WAIT;
                    end
                end
                toom_pkg::IS_B2_WAIT: begin
                    if (dy_done && !dy_start) begin
                        if (!pass) begin
                            // First pass gives c1+c5 and c2+c4
                            wk[4] <= alpha;
                            wk[5] <= dy_q;
                            wk[3] <= wk[3] ^ alpha ^ dy_q;
                            step  <= toom_pkg::IS_PASS2;
                        end else begin
                            wk[1] <= alpha;
                            wk[2] <= dy_q;
                            wk[5] <= wk[4] ^ alpha;
                            wk[4] <= wk[5] ^ dy_q;
                            done  <= 1'b1;
                            step  <= toom_pkg::IS_IDLE;
                        end
                    end
                end
                toom_pkg::IS_PASS2: begin
                    g    <= wk[1] ^ cmul(wk[3], X3) ^ cmul(wk[4], X5) ^ cmul(wk[5], X4);
                    h    <= wk[2] ^ cmul(wk[3], Y3) ^ cmul(wk[4], Y5) ^ cmul(wk[5], Y4);
                    pass <= 1'b1;
                    step <= toom_pkg::IS_SOLVE;
                end
                default: step <= toom_pkg::IS_IDLE;
            endcase
        end
    end

    assign c0 = wk[0];
    assign c1 = wk[1];
    assign c2 = wk[2];
    assign c3 = wk[3];
    assign c4 = wk[4];
    assign c5 = wk[5];
    assign c6 = wk[6];

endmodule

`default_nettype wire

// File: hdl/toom4_mul.sv
`default_nettype none

module toom4_mul #(
    parameter int LIMB_W = toom_pkg::LIMB_W_DEFAULT
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [LIMB_W-1:0]    a0, a1, a2, a3,
    input  wire logic [LIMB_W-1:0]    b0, b1, b2, b3,
    output logic      [8*LIMB_W-1:0]  w,
    output logic                      done
);

    localparam int OW = LIMB_W + toom_pkg::EVAL_EXT;
    localparam int PW = 2 * OW;
    localparam int RW = 8 * LIMB_W;
    localparam int NP = toom_pkg::NUM_POINTS;

    toom_pkg::phase_t phase;

    logic          launched;
    logic [1:0]    pair_idx;
    logic          eval_start, eval_done;
    logic          interp_start, interp_done;
    logic [OW-1:0] ua [NP];
    logic [OW-1:0] ub [NP];
    logic [PW-1:0] prod [NP];
    logic [PW-1:0] coef [NP];
    logic [OW-1:0] mx [2];
    logic [OW-1:0] my [2];
    logic [PW-1:0] mp [2];
    logic [1:0]    mstart, mdone;
    logic [RW-1:0] w_sum;

    toom4_eval #(.LIMB_W(LIMB_W)) u_eval (
        .clk(clk), .start(eval_start),
        .a0(a0), .a1(a1), .a2(a2), .a3(a3),
        .b0(b0), .b1(b1), .b2(b2), .b3(b3),
        .ua0(ua[0]), .ua1(ua[1]), .ua2(ua[2]), .ua3(ua[3]),
        .ua4(ua[4]), .ua5(ua[5]), .ua6(ua[6]),
        .ub0(ub[0]), .ub1(ub[1]), .ub2(ub[2]), .ub3(ub[3]),
        .ub4(ub[4]), .ub5(ub[5]), .ub6(ub[6]),
        .done(eval_done)
    );

    for (genvar m = 0; m < 2; m++) begin : g_mul
        clmul_serial #(.LIMB_W(LIMB_W)) u_mul (
            .clk(clk), .start(mstart[m]), .x(mx[m]), .y(my[m]), .p(mp[m]), .done(mdone[m])
        );
    end

    toom4_interp #(.LIMB_W(LIMB_W)) u_interp (
        .clk(clk), .start(interp_start),
        .r0(prod[0]), .r1(prod[1]), .r2(prod[2]), .r3(prod[3]),
        .r4(prod[4]), .r5(prod[5]), .r6(prod[6]),
        .c0(coef[0]), .c1(coef[1]), .c2(coef[2]), .c3(coef[3]),
        .c4(coef[4]), .c5(coef[5]), .c6(coef[6]),
        .done(interp_done)
    );

    // Coefficient i lands at bit i*LIMB_W in the overlap-add
    always_comb begin
        w_sum = '0;
        for (int i = 0; i < NP; i++) begin
            w_sum ^= RW'(coef[i]) << (i * LIMB_W);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= toom_pkg::PH_EVAL;
            launched     <= 1'b0;
            pair_idx     <= '0;
            eval_start   <= 1'b0;
            mstart       <= '0;
            interp_start <= 1'b0;
            done         <= 1'b0;
        end else begin
            eval_start   <= 1'b0;
            mstart       <= '0;
            interp_start <= 1'b0;
            case (phase)
                toom_pkg::PH_EVAL: begin
                    if (!launched) begin
                        eval_start <= 1'b1;
                        launched   <= 1'b1;
                    end else if (eval_done && !eval_start) begin
                        launched <= 1'b0;
                        phase    <= toom_pkg::PH_MUL_PAIR;
                    end
                end
                toom_pkg::PH_MUL_PAIR: begin
                    // Points 2i and 2i+1 share a launch and point 6 runs alone
                    mx[0]     <= ua[{pair_idx, 1'b0}];
                    my[0]     <= ub[{pair_idx, 1'b0}];
                    mstart[0] <= 1'b1;
                    if (pair_idx != 2'd3) begin
                        mx[1]     <= ua[{pair_idx, 1'b1}];
                        my[1]     <= ub[{pair_idx, 1'b1}];
                        mstart[1] <= 1'b1;
                    end
                    phase <= toom_pkg::PH_MUL_WAIT;
                end
                toom_pkg::PH_MUL_WAIT: begin
                    // The lone point 6 launch leaves the second multiplier idle
                    if (mdone[0] && !mstart[0] && (mdone[1] || pair_idx == 2'd3)) begin
                        prod[{pair_idx, 1'b0}] <= mp[0];
                        if (pair_idx != 2'd3) begin
                            prod[{pair_idx, 1'b1}] <= mp[1];
                            pair_idx <= pair_idx + 1'b1;
                            phase    <= toom_pkg::PH_MUL_PAIR;
                        end else begin
                            phase <= toom_pkg::PH_INTERP;
                        end
                    end
                end
                toom_pkg::PH_INTERP: begin
                    if (!launched) begin
                        interp_start <= 1'b1;
                        launched     <= 1'b1;
                    end else if (interp_done && !interp_start) begin
                        launched <= 1'b0;
                        phase    <= toom_pkg::PH_COMBINE;
                    end
                end
                toom_pkg::PH_COMBINE: begin
                    w     <= w_sum;
                    done  <= 1'b1;
                    phase <= toom_pkg::PH_DONE;
                end
                toom_pkg::PH_DONE: ;
                default: phase <= toom_pkg::PH_DONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: bench/toom4_mul_asserts.sv
`default_nettype none

module toom4_mul_asserts #(
    parameter int LIMB_W = toom_pkg::LIMB_W_DEFAULT
) (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 done,
    input wire logic [8*LIMB_W-1:0]  w
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reset clears done on the next edge
    a_done_low_after_reset: assert property (@(posedge clk) reset |=> !done)
        else $error("done is high in the cycle after reset");

    // Done holds until the next reset
    a_done_sticky: assert property (@(posedge clk) (done && !reset) |=> done)
        else $error("done dropped without a reset");

    a_w_stable: assert property (@(posedge clk) (done && !reset) |=> $stable(w))
        else $error("w changed while done was high");

endmodule

`default_nettype wire

// File: bench/toom4_mul_tb.sv
`default_nettype none

module toom4_mul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LIMB_W = 16;
    localparam int OW = LIMB_W + toom_pkg::EVAL_EXT;
    localparam int PW = 2 * OW;
    localparam int OPW = 4 * LIMB_W;
    localparam int RW = 8 * LIMB_W;
    // Four multiplier runs plus two interpolation passes of four divides each
    localparam int LAT_BOUND = 4 * (OW + 4) + 8 * (2 * PW + 4) + 32;
    localparam int TIMEOUT = 2 * LAT_BOUND;
    localparam int NROWS = 10;
    localparam int RESTART_ROW = 7;

    logic              clk;
    logic              reset;
    logic [LIMB_W-1:0] a0, a1, a2, a3;
    logic [LIMB_W-1:0] b0, b1, b2, b3;
    logic [RW-1:0]     w;
    logic              done;

    logic [OPW-1:0] tab_a [NROWS];
    logic [OPW-1:0] tab_b [NROWS];
    logic [RW-1:0]  tab_w [NROWS];
    int             seed;

    toom4_mul #(.LIMB_W(LIMB_W)) i_dut (
        .clk(clk), .reset(reset),
        .a0(a0), .a1(a1), .a2(a2), .a3(a3),
        .b0(b0), .b1(b1), .b2(b2), .b3(b3),
        .w(w), .done(done)
    );

    bind toom4_mul toom4_mul_asserts #(.LIMB_W(LIMB_W)) i_asserts (
        .clk(clk), .reset(reset), .done(done), .w(w)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Shift-and-XOR product over GF(2)
    function automatic logic [RW-1:0] clmul_ref(input logic [OPW-1:0] x,
            input logic [OPW-1:0] y);
        logic [RW-1:0] acc;
        acc = '0;
        for (int i = 0; i < OPW; i++) begin
            if (y[i]) begin
                acc ^= RW'(x) << i;
            end
        end
        return acc;
    endfunction

    function automatic logic [OPW-1:0] rand_operand();
        logic [OPW-1:0] v;
        v = '0;
        for (int i = 0; i < (OPW + 31) / 32; i++) begin
            v = (v << 32) ^ OPW'($unsigned($random(seed)));
        end
        return v;
    endfunction

    task automatic build_table();
        logic [OPW-1:0] top_mask;
        top_mask = {{LIMB_W{1'b1}}, {(3*LIMB_W){1'b0}}};
        for (int r = 0; r < NROWS; r++) begin
            tab_a[r] = rand_operand();
            tab_b[r] = rand_operand();
        end
        tab_a[0] = '0;
        tab_b[1] = '0;
        tab_a[2] = OPW'(1);
        // Only the top limbs set
        tab_a[3] = tab_a[3] & top_mask;
        tab_b[3] = tab_b[3] & top_mask;
        tab_a[8] = '1;
        tab_b[8] = '1;
        for (int r = 0; r < NROWS; r++) begin
            tab_w[r] = clmul_ref(tab_a[r], tab_b[r]);
        end
    endtask

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic load_operands(input logic [OPW-1:0] x, input logic [OPW-1:0] y);
        {a3, a2, a1, a0} <= x;
        {b3, b2, b1, b0} <= y;
    endtask

    task automatic pulse_reset();
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (done === 1'b1) else begin
            $display("Timed out after %0d cycles waiting for done", TIMEOUT);
            abort_run();
        end
    endtask

    initial begin
        seed = 91818;
        reset = 1'b1;
        {a3, a2, a1, a0} = '0;
        {b3, b2, b1, b0} = '0;
        build_table();
        for (int r = 0; r < NROWS; r++) begin
            if (r == RESTART_ROW) begin
                // Start a run on other operands and cut it short
                @(posedge clk);
                load_operands(rand_operand(), rand_operand());
                pulse_reset();
                repeat (LAT_BOUND / 3) @(posedge clk);
                @(negedge clk);
                assert (done === 1'b0) else begin
                    $display("done went high early in the aborted run");
                    abort_run();
                end
            end
            @(posedge clk);
            load_operands(tab_a[r], tab_b[r]);
            pulse_reset();
            @(negedge clk);
            assert (done === 1'b0) else begin
                $display("done is not low after reset in row %0d", r);
                abort_run();
            end
            wait_done();
            assert (w === tab_w[r]) else begin
                $display("CHECK FAILED w row %0d expected %h actual %h", r, tab_w[r], w);
                abort_run();
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: toom4_mul.f
hdl/toom_pkg.sv
hdl/clmul_serial.sv
hdl/gf2_exact_div.sv
hdl/toom4_eval.sv
hdl/toom4_interp.sv
hdl/toom4_mul.sv
bench/toom4_mul_asserts.sv
bench/toom4_mul_tb.sv

// File: Bender.yml
package:
  name: toom4_mul

sources:
  - hdl/toom_pkg.sv
  - hdl/clmul_serial.sv
  - hdl/gf2_exact_div.sv
  - hdl/toom4_eval.sv
  - hdl/toom4_interp.sv
  - hdl/toom4_mul.sv
  - target: simulation
    files:
      - bench/toom4_mul_asserts.sv
      - bench/toom4_mul_tb.sv
